/* Bender.yml */
package:
  name: exec_core

export_include_dirs:
  - common

sources:
  - common/mips_pkg.sv
  - regfile/regfile.sv
  - rtl/instr_decoder.sv
  - rtl/alu.sv
  - rtl/exec_core.sv
  - target: test
    files:
      - bench/tb_clock.sv
      - bench/exec_core_tb.sv

/* bench/exec_core_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mips_defs.svh"

module exec_core_tb;

    localparam int CLK_PERIOD_NS = 4;
    localparam int RESET_CYCLES  = 5;
    localparam int NUM_CYCLES    = 3000;
    // stimulus length plus a few hundred ns of slack
    localparam int WATCHDOG_NS   = (RESET_CYCLES + NUM_CYCLES + 2) * CLK_PERIOD_NS + 400;

    // kinds 0 to 17 are supported and 18 is an illegal word
    localparam int K_ADDU  = 0;
    localparam int K_SUBU  = 1;
    localparam int K_AND   = 2;
    localparam int K_OR    = 3;
    localparam int K_XOR   = 4;
    localparam int K_NOR   = 5;
    localparam int K_SLT   = 6;
    localparam int K_SLTU  = 7;
    localparam int K_SLL   = 8;
    localparam int K_SRL   = 9;
    localparam int K_SRA   = 10;
    localparam int K_ADDIU = 11;
    localparam int K_SLTI  = 12;
    localparam int K_SLTIU = 13;
    localparam int K_ANDI  = 14;
    localparam int K_ORI   = 15;
    localparam int K_XORI  = 16;
    localparam int K_LUI   = 17;
    localparam int K_ILLEGAL = 18;
    localparam int NUM_KINDS = 19;

    logic                r_clk;
    logic                reset;
    logic                r_clk_enable;
    logic                instr_valid;
    mips_pkg::word_t     instr;
    logic                retire_valid;
    mips_pkg::reg_addr_t retire_reg;
    mips_pkg::word_t     retire_data;
    logic                retire_illegal;
    mips_pkg::word_t     regfile_v0;

    // lcg state
    logic [31:0]         lcg_state;
    // what was driven at the last rising edge
    int                  drv_kind;
    logic                drv_valid;
    logic                drv_enable;
    mips_pkg::word_t     drv_instr;
    // architectural model and the retirement it expects next cycle
    mips_pkg::word_t     model_regs [`MIPS_NREGS];
    logic                exp_valid;
    mips_pkg::reg_addr_t exp_reg;
    mips_pkg::word_t     exp_data;
    logic                exp_illegal;
    string               exp_name;
    int                  op_hits [NUM_KINDS];
    int                  missing;

    tb_clock #(.PERIOD_NS(CLK_PERIOD_NS)) clock_i (.r_clk(r_clk));

    exec_core exec_core_i (
        .r_clk          (r_clk),
        .reset          (reset),
        .r_clk_enable   (r_clk_enable),
        .instr_valid    (instr_valid),
        .instr          (instr),
        .retire_valid   (retire_valid),
        .retire_reg     (retire_reg),
        .retire_data    (retire_data),
        .retire_illegal (retire_illegal),
        .regfile_v0     (regfile_v0)
    );

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Some tests failed");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic compare_word(input string name, input mips_pkg::word_t exp,
                                input mips_pkg::word_t act);
        if (exp !== act) begin
            abort_run($sformatf("Mismatch in %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic compare_reg(input string name, input mips_pkg::reg_addr_t exp,
                               input mips_pkg::reg_addr_t act);
        if (exp !== act) begin
            abort_run($sformatf("Mismatch in %s: expected %0d, actual %0d", name, exp, act));
        end
    endtask

    task automatic compare_flag(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            abort_run($sformatf("Mismatch in %s: expected %b, actual %b", name, exp, act));
        end
    endtask

    // classic 32-bit lcg whose upper bits are the useful ones
    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic int rand_below(input int n);
        return int'((next_rand() >> 16) % n);
    endfunction

    // mostly r0..r7 so results get reused soon after they are written
    function automatic mips_pkg::reg_addr_t pick_reg();
        if (rand_below(4) == 0) begin
            return mips_pkg::reg_addr_t'(rand_below(32));
        end
        return mips_pkg::reg_addr_t'(rand_below(8));
    endfunction

    // small, negative or fully random immediates
    function automatic logic [15:0] pick_imm();
        logic [31:0] r;
        r = next_rand();
        case (rand_below(4))
            0:       return 16'(r[17:16]);
            1:       return {1'b1, r[30:16]};
            default: return r[31:16];
        endcase
    endfunction

    function automatic string kind_name(input int kind);
        case (kind)
            K_ADDU:  return "addu";
            K_SUBU:  return "subu";
            K_AND:   return "and";
            K_OR:    return "or";
            K_XOR:   return "xor";
            K_NOR:   return "nor";
            K_SLT:   return "slt";
            K_SLTU:  return "sltu";
            K_SLL:   return "sll";
            K_SRL:   return "srl";
            K_SRA:   return "sra";
            K_ADDIU: return "addiu";
            K_SLTI:  return "slti";
            K_SLTIU: return "sltiu";
            K_ANDI:  return "andi";
            K_ORI:   return "ori";
            K_XORI:  return "xori";
            K_LUI:   return "lui";
            default: return "illegal";
        endcase
    endfunction

    function automatic mips_pkg::word_t r_word(input logic [4:0] rs, input logic [4:0] rt,
                                               input logic [4:0] rd, input logic [4:0] sh,
                                               input logic [5:0] fn);
        return {6'h00, rs, rt, rd, sh, fn};
    endfunction

    function automatic mips_pkg::word_t i_word(input logic [5:0] op, input logic [4:0] rs,
                                               input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic mips_pkg::word_t encode_op(input int kind,
                                                  input mips_pkg::reg_addr_t rs,
                                                  input mips_pkg::reg_addr_t rt,
                                                  input mips_pkg::reg_addr_t rd,
                                                  input logic [4:0] sh,
                                                  input logic [15:0] imm);
        case (kind)
            K_ADDU:  return r_word(rs, rt, rd, sh, mips_pkg::FN_ADDU);
            K_SUBU:  return r_word(rs, rt, rd, sh, mips_pkg::FN_SUBU);
            K_AND:   return r_word(rs, rt, rd, sh, mips_pkg::FN_AND);
            K_OR:    return r_word(rs, rt, rd, sh, mips_pkg::FN_OR);
            K_XOR:   return r_word(rs, rt, rd, sh, mips_pkg::FN_XOR);
            K_NOR:   return r_word(rs, rt, rd, sh, mips_pkg::FN_NOR);
            K_SLT:   return r_word(rs, rt, rd, sh, mips_pkg::FN_SLT);
            K_SLTU:  return r_word(rs, rt, rd, sh, mips_pkg::FN_SLTU);
            K_SLL:   return r_word(rs, rt, rd, sh, mips_pkg::FN_SLL);
            K_SRL:   return r_word(rs, rt, rd, sh, mips_pkg::FN_SRL);
            K_SRA:   return r_word(rs, rt, rd, sh, mips_pkg::FN_SRA);
            K_ADDIU: return i_word(mips_pkg::OP_ADDIU, rs, rt, imm);
            K_SLTI:  return i_word(mips_pkg::OP_SLTI, rs, rt, imm);
            K_SLTIU: return i_word(mips_pkg::OP_SLTIU, rs, rt, imm);
            K_ANDI:  return i_word(mips_pkg::OP_ANDI, rs, rt, imm);
            K_ORI:   return i_word(mips_pkg::OP_ORI, rs, rt, imm);
            K_XORI:  return i_word(mips_pkg::OP_XORI, rs, rt, imm);
            default: return i_word(mips_pkg::OP_LUI, rs, rt, imm);
        endcase
    endfunction

    // real mips encodings outside the supported set such as add, addi, lw and jr
    function automatic mips_pkg::word_t illegal_word();
        logic [31:0] r;
        int          sel;
        sel = rand_below(8);
        r   = next_rand();
        case (sel)
            0:       return {6'h02, r[25:0]};
            1:       return {6'h04, r[25:0]};
            2:       return {6'h08, r[25:0]};
            3:       return {6'h23, r[25:0]};
            4:       return {6'h00, r[25:6], 6'h20};
            5:       return {6'h00, r[25:6], 6'h22};
            6:       return {6'h00, r[25:6], 6'h08};
            default: return {6'h00, r[25:6], 6'h18};
        endcase
    endfunction

    // two's complement order decided by the sign bits first
    function automatic logic signed_less(input mips_pkg::word_t x, input mips_pkg::word_t y);
        if (x[31] != y[31]) begin
            return x[31];
        end
        return x < y;
    endfunction

    // reference semantics with operands read before the write lands
    task automatic model_exec(input int kind, input mips_pkg::word_t w,
                              output mips_pkg::reg_addr_t dest, output mips_pkg::word_t data,
                              output logic bad);
        mips_pkg::word_t a;
        mips_pkg::word_t b;
        mips_pkg::word_t sext;
        mips_pkg::word_t zext;
        logic [4:0]      sh;
        a    = model_regs[w[25:21]];
        b    = model_regs[w[20:16]];
        sext = {{16{w[15]}}, w[15:0]};
        zext = {16'h0000, w[15:0]};
        sh   = w[10:6];
        bad  = 1'b0;
        // r-type targets rd and i-type targets rt
        dest = (kind <= K_SRA) ? w[15:11] : w[20:16];
        case (kind)
            K_ADDU:  data = a + b;
            K_SUBU:  data = a - b;
            K_AND:   data = a & b;
            K_OR:    data = a | b;
            K_XOR:   data = a ^ b;
            K_NOR:   data = ~(a | b);
            K_SLT:   data = signed_less(a, b) ? 32'd1 : 32'd0;
            K_SLTU:  data = (a < b) ? 32'd1 : 32'd0;
            K_SLL:   data = b << sh;
            K_SRL:   data = b >> sh;
            // logical shift with the vacated top bits filled from the sign
            K_SRA:   data = (b >> sh) | ({32{b[31]}} & ~(32'hffff_ffff >> sh));
            K_ADDIU: data = a + sext;
            K_SLTI:  data = signed_less(a, sext) ? 32'd1 : 32'd0;
            K_SLTIU: data = (a < sext) ? 32'd1 : 32'd0;
            K_ANDI:  data = a & zext;
            K_ORI:   data = a | zext;
            K_XORI:  data = a ^ zext;
            K_LUI:   data = {w[15:0], 16'h0000};
            default: begin
                // illegal words have no destination and no data
                dest = '0;
                data = '0;
                bad  = 1'b1;
            end
        endcase
    endtask

    task automatic drive_random();
        mips_pkg::reg_addr_t rs;
        mips_pkg::reg_addr_t rt;
        mips_pkg::reg_addr_t rd;
        logic [4:0]          sh;
        logic [15:0]         imm;
        int                  kind;
        logic                v;
        logic                en;
        mips_pkg::word_t     w;
        // about 5% illegal words
        kind = (rand_below(100) < 5) ? K_ILLEGAL : rand_below(18);
        rs   = pick_reg();
        rt   = pick_reg();
        rd   = pick_reg();
        sh   = 5'(rand_below(32));
        imm  = pick_imm();
        w    = (kind == K_ILLEGAL) ? illegal_word() : encode_op(kind, rs, rt, rd, sh, imm);
        v    = rand_below(4) != 0;
        en   = rand_below(5) != 0;
        instr_valid  <= v;
        r_clk_enable <= en;
        instr        <= w;
        drv_kind   = kind;
        drv_valid  = v;
        drv_enable = en;
        drv_instr  = w;
    endtask

    // retirement seen now belongs to the instruction driven one edge earlier
    task automatic check_outputs(input int cycle);
        compare_flag($sformatf("cycle %0d retire_valid", cycle), exp_valid, retire_valid);
        if (exp_valid) begin
            compare_reg($sformatf("%s retire_reg, cycle %0d", exp_name, cycle),
                        exp_reg, retire_reg);
            compare_word($sformatf("%s retire_data, cycle %0d", exp_name, cycle),
                         exp_data, retire_data);
            compare_flag($sformatf("%s retire_illegal, cycle %0d", exp_name, cycle),
                         exp_illegal, retire_illegal);
        end
        compare_word($sformatf("regfile_v0, cycle %0d", cycle),
                     model_regs[`MIPS_V0_IDX], regfile_v0);
    endtask

    task automatic apply_model();
        mips_pkg::reg_addr_t dest;
        mips_pkg::word_t     data;
        logic                bad;
        // stalled or idle cycles leave the model alone
        exp_valid = drv_valid && drv_enable;
        if (exp_valid) begin
            model_exec(drv_kind, drv_instr, dest, data, bad);
            exp_reg     = dest;
            exp_data    = data;
            exp_illegal = bad;
            exp_name    = kind_name(drv_kind);
            op_hits[drv_kind]++;
            // r0 is never written and keeps reading zero
            if (!bad && dest != '0) begin
                model_regs[dest] = data;
            end
        end
    endtask

    initial begin
        #(WATCHDOG_NS);
        abort_run($sformatf("watchdog expired after %0d ns and the run did not finish",
                            WATCHDOG_NS));
    end

    initial begin
        lcg_state    = 32'd39460;
        reset        = 1'b1;
        r_clk_enable = 1'b0;
        instr_valid  = 1'b0;
        instr        = '0;
        exp_valid    = 1'b0;
        exp_reg      = '0;
        exp_data     = '0;
        exp_illegal  = 1'b0;
        exp_name     = "none";
        drv_kind     = K_ILLEGAL;
        drv_valid    = 1'b0;
        drv_enable   = 1'b0;
        drv_instr    = '0;
        for (int i = 0; i < `MIPS_NREGS; i++) begin
            model_regs[i] = '0;
        end
        for (int k = 0; k < NUM_KINDS; k++) begin
            op_hits[k] = 0;
        end

        repeat (RESET_CYCLES) @(posedge r_clk);
        reset <= 1'b0;

        // state straight out of reset
        @(negedge r_clk);
        compare_flag("after reset retire_valid", 1'b0, retire_valid);
        compare_flag("after reset retire_illegal", 1'b0, retire_illegal);
        compare_reg("after reset retire_reg", '0, retire_reg);
        compare_word("after reset retire_data", '0, retire_data);
        compare_word("after reset regfile_v0", '0, regfile_v0);

        // drive on the rising edge and check on the falling one
        for (int cycle = 0; cycle < NUM_CYCLES; cycle++) begin
            @(posedge r_clk);
            drive_random();
            @(negedge r_clk);
            check_outputs(cycle);
            apply_model();
        end

        // drain the last report
        @(posedge r_clk);
        instr_valid <= 1'b0;
        @(negedge r_clk);
        check_outputs(NUM_CYCLES);

        missing = 0;
        for (int k = 0; k < NUM_KINDS; k++) begin
            if (op_hits[k] == 0) begin
                missing++;
            end
        end
        if (missing == 0) begin
            $display("All tests passed");
            $finish;
        end else begin
            abort_run($sformatf("%0d instruction kinds were never accepted", missing));
        end
    end

endmodule

`default_nettype wire

/* bench/tb_clock.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter int PERIOD_NS = 4
) (
    output logic r_clk
);

    // free running, starts low so the first rising edge is half a period in
    initial begin
        r_clk = 1'b0;
    end

    always begin
        #(PERIOD_NS / 2.0);
        r_clk = ~r_clk;
    end

endmodule

`default_nettype wire

/* common/mips_defs.svh */
`ifndef MIPS_DEFS_SVH
`define MIPS_DEFS_SVH

// data path width, also the instruction word width
`define MIPS_XLEN 32

// architectural register count
`define MIPS_NREGS 32

// bits needed to name one register
`define MIPS_RADDR_W 5

// return value register, tapped out of the register file
`define MIPS_V0_IDX 2

`endif

/* common/mips_pkg.sv */
`default_nettype none

`include "mips_defs.svh"

package mips_pkg;

    // one data or instruction word
    typedef logic [`MIPS_XLEN-1:0] word_t;

    // register number, as found in the rs, rt and rd fields
    typedef logic [`MIPS_RADDR_W-1:0] reg_addr_t;

    // operations the alu knows about
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_NOR  = 4'd5,
        ALU_SLT  = 4'd6,
        ALU_SLTU = 4'd7,
        ALU_SLL  = 4'd8,
        ALU_SRL  = 4'd9,
        ALU_SRA  = 4'd10,
        ALU_LUI  = 4'd11
    } alu_op_t;

    // primary opcodes in bits 31:26
    // only the alu group is listed, the rest decode as illegal
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_ADDIU   = 6'h09,
        OP_SLTI    = 6'h0a,
        OP_SLTIU   = 6'h0b,
        OP_ANDI    = 6'h0c,
        OP_ORI     = 6'h0d,
        OP_XORI    = 6'h0e,
        OP_LUI     = 6'h0f
    } opcode_t;

    // r-type function codes in bits 5:0
    typedef enum logic [5:0] {
        FN_SLL  = 6'h00,
        FN_SRL  = 6'h02,
        FN_SRA  = 6'h03,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_NOR  = 6'h27,
        FN_SLT  = 6'h2a,
        FN_SLTU = 6'h2b
    } funct_t;

endpackage

`default_nettype wire

/* flist.f */
+incdir+common
common/mips_pkg.sv
regfile/regfile.sv
rtl/instr_decoder.sv
rtl/alu.sv
rtl/exec_core.sv
bench/tb_clock.sv
bench/exec_core_tb.sv

/* regfile/regfile.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mips_defs.svh"

module regfile (
    input  logic               r_clk,
    input  logic               reset,
    input  logic               r_clk_enable,
    // write request from the core, already qualified by instr_valid
    input  logic               write_control,
    // source register numbers
    input  mips_pkg::reg_addr_t read_reg1,
    input  mips_pkg::reg_addr_t read_reg2,
    // destination and the value going into it
    input  mips_pkg::reg_addr_t write_reg,
    input  mips_pkg::word_t     write_data,
    // combinational read data
    output mips_pkg::word_t     read_data1,
    output mips_pkg::word_t     read_data2,
    // v0 shown to the outside at all times
    output mips_pkg::word_t     regfile_v0
);

    mips_pkg::word_t registers [`MIPS_NREGS];

    // whole array comes up zero after reset
    // r_clk_enable low freezes the contents
    always_ff @(posedge r_clk) begin
        if (reset) begin
            for (int i = 0; i < `MIPS_NREGS; i++) begin
                registers[i] <= '0;
            end
        end else if (r_clk_enable && write_control && (write_reg != '0)) begin
            // writes to $zero are dropped here
            registers[write_reg] <= write_data;
        end
    end

    // $zero reads zero regardless of array contents
    assign read_data1 = (read_reg1 == '0) ? '0 : registers[read_reg1];
    assign read_data2 = (read_reg2 == '0) ? '0 : registers[read_reg2];

    // v0 tap, updates the cycle after a write to register 2
    assign regfile_v0 = registers[`MIPS_V0_IDX];

endmodule

`default_nettype wire

/* rtl/alu.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mips_defs.svh"

module alu (
    // rs value
    input  mips_pkg::word_t   operand_a,
    // rt value, also the shift source
    input  mips_pkg::word_t   reg_b,
    input  mips_pkg::word_t   imm_value,
    input  logic              use_imm,
    input  mips_pkg::alu_op_t alu_op,
    input  logic [4:0]        shamt,
    output mips_pkg::word_t   result
);

    mips_pkg::word_t operand_b;
    logic            lt_signed;
    logic            lt_unsigned;

    // second operand select
    assign operand_b = use_imm ? imm_value : reg_b;

    // both compares run all the time, op picks one
    assign lt_signed   = $signed(operand_a) < $signed(operand_b);
    assign lt_unsigned = operand_a < operand_b;

    always_comb begin
        case (alu_op)
            // add and sub wrap, no overflow trap
            mips_pkg::ALU_ADD:  result = operand_a + operand_b;
            mips_pkg::ALU_SUB:  result = operand_a - operand_b;
            mips_pkg::ALU_AND:  result = operand_a & operand_b;
            mips_pkg::ALU_OR:   result = operand_a | operand_b;
            mips_pkg::ALU_XOR:  result = operand_a ^ operand_b;
            mips_pkg::ALU_NOR:  result = ~(operand_a | operand_b);
            // set less than gives 0 or 1
            mips_pkg::ALU_SLT:  result = {{(`MIPS_XLEN-1){1'b0}}, lt_signed};
            mips_pkg::ALU_SLTU: result = {{(`MIPS_XLEN-1){1'b0}}, lt_unsigned};
            // shifts always act on rt by the shamt field
            mips_pkg::ALU_SLL:  result = reg_b << shamt;
            mips_pkg::ALU_SRL:  result = reg_b >> shamt;
            mips_pkg::ALU_SRA:  result = mips_pkg::word_t'($signed(reg_b) >>> shamt);
            // decoder already moved the immediate to the upper half
            mips_pkg::ALU_LUI:  result = imm_value;
            default:            result = '0;
        endcase
    end

endmodule

`default_nettype wire

/* rtl/exec_core.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_core (
    input  logic                r_clk,
    input  logic                reset,
    // low level stalls the whole slice
    input  logic                r_clk_enable,
    // one instruction per high cycle
    input  logic                instr_valid,
    input  mips_pkg::word_t     instr,
    // retirement report, one cycle after the accepting edge
    output logic                retire_valid,
    output mips_pkg::reg_addr_t retire_reg,
    output mips_pkg::word_t     retire_data,
    output logic                retire_illegal,
    output mips_pkg::word_t     regfile_v0
);

    mips_pkg::reg_addr_t rs_addr;
    mips_pkg::reg_addr_t rt_addr;
    mips_pkg::reg_addr_t dest_reg;
    mips_pkg::alu_op_t   alu_op;
    logic                use_imm;
    mips_pkg::word_t     imm_value;
    logic [4:0]          shamt;
    logic                writes_reg;
    logic                illegal;
    mips_pkg::word_t     read_data1;
    mips_pkg::word_t     read_data2;
    mips_pkg::word_t     alu_result;
    logic                accept;
    logic                write_control;

    // instruction is taken only when valid and not stalled
    assign accept = instr_valid && r_clk_enable;

    // regfile adds the clock enable and the $zero check itself
    assign write_control = instr_valid && writes_reg;

    instr_decoder decoder_i (
        .instr      (instr),
        .rs_addr    (rs_addr),
        .rt_addr    (rt_addr),
        .dest_reg   (dest_reg),
        .alu_op     (alu_op),
        .use_imm    (use_imm),
        .imm_value  (imm_value),
        .shamt      (shamt),
        .writes_reg (writes_reg),
        .illegal    (illegal)
    );

    regfile regfile_i (
        .r_clk         (r_clk),
        .reset         (reset),
        .r_clk_enable  (r_clk_enable),
        .write_control (write_control),
        .read_reg1     (rs_addr),
        .read_reg2     (rt_addr),
        .write_reg     (dest_reg),
        .write_data    (alu_result),
        .read_data1    (read_data1),
        .read_data2    (read_data2),
        .regfile_v0    (regfile_v0)
    );

    alu alu_i (
        .operand_a (read_data1),
        .reg_b     (read_data2),
        .imm_value (imm_value),
        .use_imm   (use_imm),
        .alu_op    (alu_op),
        .shamt     (shamt),
        .result    (alu_result)
    );

    // retirement register
    // valid follows accept every edge, so a stall never repeats a report
    always_ff @(posedge r_clk) begin
        if (reset) begin
            retire_valid   <= 1'b0;
            retire_reg     <= '0;
            retire_data    <= '0;
            retire_illegal <= 1'b0;
        end else begin
            retire_valid <= accept;
            if (accept) begin
                retire_reg     <= dest_reg;
                // illegal words report zero data
                retire_data    <= illegal ? '0 : alu_result;
                retire_illegal <= illegal;
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/instr_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mips_defs.svh"

module instr_decoder (
    input  mips_pkg::word_t     instr,
    // source register fields passed straight through
    output mips_pkg::reg_addr_t rs_addr,
    output mips_pkg::reg_addr_t rt_addr,
    // rd for r-type, rt for i-type and zero when illegal
    output mips_pkg::reg_addr_t dest_reg,
    output mips_pkg::alu_op_t   alu_op,
    // second operand comes from imm_value instead of rt
    output logic                use_imm,
    output mips_pkg::word_t     imm_value,
    output logic [4:0]          shamt,
    output logic                writes_reg,
    output logic                illegal
);

    mips_pkg::opcode_t   opcode;
    mips_pkg::funct_t    funct;
    mips_pkg::reg_addr_t rd_field;
    logic [15:0]         imm16;
    mips_pkg::word_t     sext_imm;
    mips_pkg::word_t     zext_imm;
    mips_pkg::word_t     lui_imm;
    // set by the classify block when the word is one we support
    logic                legal;
    mips_pkg::reg_addr_t dest_sel;

    // field split
    assign opcode   = mips_pkg::opcode_t'(instr[31:26]);
    assign rs_addr  = instr[25:21];
    assign rt_addr  = instr[20:16];
    assign rd_field = instr[15:11];
    assign shamt    = instr[10:6];
    assign funct    = mips_pkg::funct_t'(instr[5:0]);
    assign imm16    = instr[15:0];

    // three flavours of immediate
    assign sext_imm = {{(`MIPS_XLEN-16){imm16[15]}}, imm16};
    assign zext_imm = {{(`MIPS_XLEN-16){1'b0}}, imm16};
    assign lui_imm  = {imm16, {(`MIPS_XLEN-16){1'b0}}};

    always_comb begin
        // defaults describe addiu and the other cases override them
        alu_op    = mips_pkg::ALU_ADD;
        use_imm   = 1'b1;
        imm_value = sext_imm;
        dest_sel  = rt_addr;
        legal     = 1'b1;
        case (opcode)
            mips_pkg::OP_SPECIAL: begin
                use_imm  = 1'b0;
                dest_sel = rd_field;
                case (funct)
                    mips_pkg::FN_ADDU: alu_op = mips_pkg::ALU_ADD;
                    mips_pkg::FN_SUBU: alu_op = mips_pkg::ALU_SUB;
                    mips_pkg::FN_AND:  alu_op = mips_pkg::ALU_AND;
                    mips_pkg::FN_OR:   alu_op = mips_pkg::ALU_OR;
                    mips_pkg::FN_XOR:  alu_op = mips_pkg::ALU_XOR;
                    mips_pkg::FN_NOR:  alu_op = mips_pkg::ALU_NOR;
                    mips_pkg::FN_SLT:  alu_op = mips_pkg::ALU_SLT;
                    mips_pkg::FN_SLTU: alu_op = mips_pkg::ALU_SLTU;
                    mips_pkg::FN_SLL:  alu_op = mips_pkg::ALU_SLL;
                    mips_pkg::FN_SRL:  alu_op = mips_pkg::ALU_SRL;
                    mips_pkg::FN_SRA:  alu_op = mips_pkg::ALU_SRA;
                    default:           legal  = 1'b0;
                endcase
            end
            // arithmetic immediates are sign extended
            mips_pkg::OP_ADDIU: alu_op = mips_pkg::ALU_ADD;
            mips_pkg::OP_SLTI:  alu_op = mips_pkg::ALU_SLT;
            // sltiu sign extends too and compares unsigned
            mips_pkg::OP_SLTIU: alu_op = mips_pkg::ALU_SLTU;
            // logic immediates are zero extended
            mips_pkg::OP_ANDI: begin
                alu_op    = mips_pkg::ALU_AND;
                imm_value = zext_imm;
            end
            mips_pkg::OP_ORI: begin
                alu_op    = mips_pkg::ALU_OR;
                imm_value = zext_imm;
            end
            mips_pkg::OP_XORI: begin
                alu_op    = mips_pkg::ALU_XOR;
                imm_value = zext_imm;
            end
            mips_pkg::OP_LUI: begin
                alu_op    = mips_pkg::ALU_LUI;
                imm_value = lui_imm;
            end
            default: legal = 1'b0;
        endcase
    end

    // illegal words name no destination and write nothing
    assign dest_reg   = legal ? dest_sel : '0;
    assign writes_reg = legal;
    assign illegal    = ~legal;

endmodule

`default_nettype wire
